// ==== rtl/heapPkg.sv ====
// Action codes keep the numbering of the original heap command set
// Error codes are a small enumeration and errNone is always zero
package heapPkg;

  //--------------------------------------------------
  // Caller actions, one per clock
  //--------------------------------------------------
  typedef enum logic [7:0] {
    actIdle     = 8'd0,    // Nothing happens
    actWrite    = 8'd2,    // Store an element, grow size if needed
    actRead     = 8'd3,    // Fetch an element
    actSize     = 8'd4,    // Current block size
    actUp       = 8'd10,   // Insert and shift tail up
    actDown     = 8'd11,   // Remove and shift tail down
    actPush     = 8'd14,   // Append at size
    actPop      = 8'd15,   // Take the last element
    actResize   = 8'd17,   // Set size directly
    actAlloc    = 8'd18,   // Claim a block
    actFree     = 8'd19,   // Give a block back
    actAdd      = 8'd20,   // Add, return new value
    actAddAfter = 8'd21,   // Add, return old value
    actSubtract = 8'd22,   // Subtract, return new value
    actOr       = 8'd28,   // Bitwise or
    actXor      = 8'd29,   // Bitwise xor
    actAnd      = 8'd30    // Bitwise and
  } heapAction_t;

  //--------------------------------------------------
  // Outcome of each action
  //--------------------------------------------------
  typedef enum logic [3:0] {
    errNone,               // Action succeeded
    errNotAllocated,       // Block above high-water count
    errFreed,              // Block has been freed
    errOutOfBounds,        // Index not below size
    errFull,               // Push on a full block
    errEmpty,              // Pop or Down on an empty block
    errOutOfMemory,        // Every block in use
    errTooLarge            // Resize beyond block length
  } heapError_t;

endpackage

// ==== rtl/heapIfs.sv ====
// Links between heapControl and the datapath storage
// All strobes are single-cycle and act on the rising edge
`timescale 1ns/1ps

interface elementPortIf #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
);
  logic [addressBits-1:0] array;        // Block being worked on
  logic [indexBits-1:0]   index;        // Element within block
  logic [dataBits-1:0]    data;         // Value to store
  logic [indexBits:0]     size;         // Block size for shifts
  logic                   writeEnable;  // Store data at index
  logic                   shiftUp;      // Open a gap at index
  logic                   shiftDown;    // Close the gap at index
  logic [dataBits-1:0]    readData;     // Element at array and index

  modport controller (output array, index, data, size, writeEnable, shiftUp, shiftDown,
                      input readData);
  modport store (input array, index, data, size, writeEnable, shiftUp, shiftDown,
                 output readData);
endinterface

interface sizePortIf #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2
);
  logic [addressBits-1:0] array;        // Block whose size is used
  logic [indexBits:0]     size;         // Size read back
  logic                   writeEnable;  // Replace the size
  logic [indexBits:0]     newSize;      // Size to store

  modport controller (output array, writeEnable, newSize, input size);
  modport tbl (input array, writeEnable, newSize, output size);
endinterface

// ==== rtl/elementAlu.sv ====
// Purely combinational; arithmetic wraps at dataBits
`timescale 1ns/1ps

module elementAlu import heapPkg::*; #(
  parameter int dataBits = 12
) (
  input  heapAction_t         action,
  input  logic [dataBits-1:0] element,    // Current stored value
  input  logic [dataBits-1:0] operand,
  output logic [dataBits-1:0] newValue,
  output logic [dataBits-1:0] result
);

  always_comb begin
    case (action)
      actSubtract: newValue = element - operand;
      actAnd:      newValue = element & operand;
      actOr:       newValue = element | operand;
      actXor:      newValue = element ^ operand;
      default:     newValue = element + operand;    // Add and AddAfter
    endcase
  end

  assign result = (action == actAddAfter) ? element : newValue; // AddAfter returns the old value

endmodule

// ==== rtl/elementStore.sv ====
// Element memory of every block, contents undefined until written
// Shifts move a whole block in one cycle and stay within its size
`timescale 1ns/1ps

module elementStore #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic        clock,
  elementPortIf.store elementPort
);
  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  logic [dataBits-1:0] memory [arrays][arrayLength];

  assign elementPort.readData = memory[elementPort.array][elementPort.index];

  //--------------------------------------------------
  // Single write and block shifts
  //--------------------------------------------------
  always_ff @(posedge clock) begin
    if (elementPort.writeEnable) begin
      memory[elementPort.array][elementPort.index] <= elementPort.data;
    end else if (elementPort.shiftUp) begin
      for (int k = 1; k < arrayLength; k++) begin
        if (k > elementPort.index && k <= elementPort.size) begin
          memory[elementPort.array][k] <= memory[elementPort.array][k-1]; // Old values move up
        end
      end
      memory[elementPort.array][elementPort.index] <= elementPort.data;  // Fill the gap
    end else if (elementPort.shiftDown) begin
      for (int k = 0; k < arrayLength - 1; k++) begin
        if (k >= elementPort.index && k + 1 < elementPort.size) begin
          memory[elementPort.array][k] <= memory[elementPort.array][k+1]; // Close over index
        end
      end
    end
  end

  // Control never asks for two memory operations at once
  assert property (@(posedge clock)
    $onehot0({elementPort.writeEnable, elementPort.shiftUp, elementPort.shiftDown}));

endmodule

// ==== rtl/sizeTable.sv ====
// One size per block, all zero after reset
`timescale 1ns/1ps

module sizeTable #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2
) (
  input  logic  clock,
  input  logic  resetN,
  sizePortIf.tbl sizePort
);
  localparam int arrays = 2 ** addressBits;

  logic [indexBits:0] sizes [arrays];                 // 0 to arrayLength inclusive

  assign sizePort.size = sizes[sizePort.array];       // Same-cycle lookup

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int k = 0; k < arrays; k++) begin
        sizes[k] <= '0;
      end
    end else if (sizePort.writeEnable) begin
      sizes[sizePort.array] <= sizePort.newSize;
    end
  end

endmodule

// ==== rtl/blockAllocator.sv ====
// Freed blocks are reused last-in first-out before fresh ones are taken
// allocate is only strobed when outOfMemory is low
`timescale 1ns/1ps

module blockAllocator import heapPkg::*; #(
  parameter int addressBits = 2
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   allocate,
  input  logic                   releaseBlock,
  input  logic [addressBits-1:0] queryArray,
  output logic [addressBits-1:0] grantArray,
  output logic                   outOfMemory,
  output heapError_t             accessError
);
  localparam int arrays = 2 ** addressBits;

  logic [addressBits:0]   highWater;                  // Blocks ever handed out
  logic [addressBits:0]   stackTop;                   // Entries on the freed stack
  logic [addressBits:0]   topMinusOne;
  logic [arrays-1:0]      allocated;                  // One flag per block
  logic [addressBits-1:0] freedStack [arrays];

  assign topMinusOne = stackTop - 1'b1;
  assign grantArray  = (stackTop != '0) ? freedStack[topMinusOne[addressBits-1:0]]
                                        : highWater[addressBits-1:0];
  assign outOfMemory = (stackTop == '0) && (highWater == arrays);

  always_comb begin
    if ({1'b0, queryArray} >= highWater) accessError = errNotAllocated;
    else if (!allocated[queryArray])     accessError = errFreed;
    else                                 accessError = errNone;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      highWater <= '0;
      stackTop  <= '0;
      allocated <= '0;
    end else if (allocate) begin
      if (stackTop != '0) stackTop <= topMinusOne;    // Reuse most recent free
      else                highWater <= highWater + 1'b1;
      allocated[grantArray] <= 1'b1;
    end else if (releaseBlock) begin
      stackTop              <= stackTop + 1'b1;
      allocated[queryArray] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseBlock) freedStack[stackTop[addressBits-1:0]] <= queryArray;
  end

  // Double frees are refused, so the stack never overfills
  assert property (@(posedge clock) disable iff (!resetN) stackTop <= arrays);

endmodule

// ==== rtl/heapControl.sv ====
// Decodes one action per clock; out and error register at the sampling edge
// dataBits must be at least indexBits+1 so a size fits on out
`timescale 1ns/1ps

module heapControl import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  heapAction_t            action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapError_t             error,
  elementPortIf.controller       elementPort,
  sizePortIf.controller          sizePort,
  output logic                   allocate,
  output logic                   releaseBlock,
  output logic [addressBits-1:0] queryArray,
  input  logic [addressBits-1:0] grantArray,
  input  logic                   outOfMemory,
  input  heapError_t             accessError,
  output heapAction_t            aluAction,
  output logic [dataBits-1:0]    aluElement,
  output logic [dataBits-1:0]    aluOperand,
  input  logic [dataBits-1:0]    aluNewValue,
  input  logic [dataBits-1:0]    aluResult
);
  localparam int arrayLength = 2 ** indexBits;

  logic [indexBits:0]  size;            // Size of the addressed block
  logic [indexBits:0]  sizeMinusOne;    // Slot of the last element
  logic                inBounds;        // Index below size
  logic                notFull;         // Room for one more
  heapError_t          boundsError;     // Access check plus index check
  heapError_t          nextError;
  logic [dataBits-1:0] nextOut;
  logic                updateOut;       // Action defines out

  assign size         = sizePort.size;
  assign sizeMinusOne = size - 1'b1;
  assign inBounds     = {1'b0, index} < size;
  assign notFull      = size < arrayLength;
  assign boundsError  = (accessError != errNone) ? accessError :
                        (inBounds ? errNone : errOutOfBounds);

  assign queryArray        = array;
  assign elementPort.array = array;
  assign elementPort.size  = size;
  assign aluAction         = action;
  assign aluElement        = elementPort.readData;
  assign aluOperand        = in;

  //--------------------------------------------------
  // Decode and strobe steering
  //--------------------------------------------------
  always_comb begin
    nextError               = errNone;
    nextOut                 = elementPort.readData;
    updateOut               = 1'b0;
    elementPort.index       = index;
    elementPort.data        = in;
    elementPort.writeEnable = 1'b0;
    elementPort.shiftUp     = 1'b0;
    elementPort.shiftDown   = 1'b0;
    sizePort.array          = array;
    sizePort.writeEnable    = 1'b0;
    sizePort.newSize        = size;
    allocate                = 1'b0;
    releaseBlock            = 1'b0;
    case (action)
      actWrite: begin
        nextError = accessError;
        if (accessError == errNone) begin
          elementPort.writeEnable = 1'b1;
          updateOut               = 1'b1;
          nextOut                 = in;
          if (!inBounds) begin                           // Writing past the end grows it
            sizePort.writeEnable = 1'b1;
            sizePort.newSize     = {1'b0, index} + 1'b1;
          end
        end
      end
      actRead: begin
        nextError = boundsError;
        updateOut = (boundsError == errNone);
      end
      actSize: begin
        nextError = accessError;
        updateOut = (accessError == errNone);
        nextOut   = dataBits'(size);
      end
      actPush: begin
        nextError = (accessError != errNone) ? accessError : (notFull ? errNone : errFull);
        elementPort.index = size[indexBits-1:0];         // Next free slot
        if (nextError == errNone) begin
          elementPort.writeEnable = 1'b1;
          sizePort.writeEnable    = 1'b1;
          sizePort.newSize        = size + 1'b1;
        end
      end
      actPop: begin
        nextError = (accessError != errNone) ? accessError :
                    ((size != '0) ? errNone : errEmpty);
        elementPort.index = sizeMinusOne[indexBits-1:0]; // Last element
        if (nextError == errNone) begin
          sizePort.writeEnable = 1'b1;
          sizePort.newSize     = sizeMinusOne;
          updateOut            = 1'b1;
        end
      end
      actUp: begin
        nextError = accessError;
        if (accessError == errNone) begin
          elementPort.shiftUp  = 1'b1;
          sizePort.writeEnable = notFull;                // Full block drops its last element
          sizePort.newSize     = size + 1'b1;
        end
      end
      actDown: begin
        nextError = (accessError != errNone) ? accessError :
                    ((size != '0) ? errNone : errEmpty);
        if (nextError == errNone) begin
          elementPort.shiftDown = 1'b1;
          sizePort.writeEnable  = 1'b1;
          sizePort.newSize      = sizeMinusOne;
          updateOut             = 1'b1;                  // Removed element
        end
      end
      actResize: begin
        nextError = (accessError != errNone) ? accessError :
                    ((in > dataBits'(arrayLength)) ? errTooLarge : errNone);
        sizePort.newSize = in[indexBits:0];
        sizePort.writeEnable = (nextError == errNone);
      end
      actAlloc: begin
        nextError      = outOfMemory ? errOutOfMemory : errNone;
        sizePort.array = grantArray;                     // New block starts empty
        if (!outOfMemory) begin
          allocate             = 1'b1;
          sizePort.writeEnable = 1'b1;
          sizePort.newSize     = '0;
          updateOut            = 1'b1;
          nextOut              = dataBits'(grantArray);
        end
      end
      actFree: begin
        nextError    = accessError;
        releaseBlock = (accessError == errNone);
      end
      actAdd, actAddAfter, actSubtract, actAnd, actOr, actXor: begin
        nextError        = boundsError;
        elementPort.data = aluNewValue;
        if (boundsError == errNone) begin
          elementPort.writeEnable = 1'b1;
          updateOut               = 1'b1;
          nextOut                 = aluResult;
        end
      end
      default: ;                                         // Idle
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      out   <= '0;
      error <= errNone;
    end else if (action != actIdle) begin
      error <= nextError;
      if (updateOut) out <= nextOut;                     // Only on success
    end
  end

  // Caller only ever presents defined action codes
  assert property (@(posedge clock) disable iff (!resetN)
    action inside {actIdle, actWrite, actRead, actSize, actUp, actDown, actPush, actPop,
                   actResize, actAlloc, actFree, actAdd, actAddAfter, actSubtract,
                   actOr, actXor, actAnd});

endmodule

// ==== rtl/arrayHeap.sv ====
// Array heap top level, one action per clock with one cycle latency
// 2**addressBits blocks of 2**indexBits elements each
`timescale 1ns/1ps

module arrayHeap import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  heapAction_t            action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapError_t             error
);
  logic                   allocate;
  logic                   releaseBlock;
  logic [addressBits-1:0] queryArray;
  logic [addressBits-1:0] grantArray;
  logic                   outOfMemory;
  heapError_t             accessError;
  heapAction_t            aluAction;
  logic [dataBits-1:0]    aluElement;
  logic [dataBits-1:0]    aluOperand;
  logic [dataBits-1:0]    aluNewValue;
  logic [dataBits-1:0]    aluResult;

  elementPortIf #(addressBits, indexBits, dataBits) elementPort ();
  sizePortIf #(addressBits, indexBits)              sizePort ();

  heapControl #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    u_heapControl (
    .clock, .resetN, .action, .array, .index, .in, .out, .error,
    .elementPort (elementPort.controller),
    .sizePort    (sizePort.controller),
    .allocate, .releaseBlock, .queryArray, .grantArray, .outOfMemory, .accessError,
    .aluAction, .aluElement, .aluOperand, .aluNewValue, .aluResult
  );

  blockAllocator #(.addressBits(addressBits)) u_blockAllocator (
    .clock, .resetN, .allocate, .releaseBlock, .queryArray, .grantArray,
    .outOfMemory, .accessError
  );

  sizeTable #(.addressBits(addressBits), .indexBits(indexBits)) u_sizeTable (
    .clock, .resetN, .sizePort (sizePort.tbl)
  );

  elementStore #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    u_elementStore (
    .clock, .elementPort (elementPort.store)
  );

  elementAlu #(.dataBits(dataBits)) u_elementAlu (
    .action   (aluAction),
    .element  (aluElement),
    .operand  (aluOperand),
    .newValue (aluNewValue),
    .result   (aluResult)
  );

endmodule

// ==== tb/clockGen.sv ====
// Free-running testbench clock with an active-low reset at start-up
// Reset releases a couple of ns after the last reset edge
`timescale 1ns/1ps

module clockGen #(
  parameter int period      = 20,
  parameter int resetCycles = 3
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;   // 50 percent duty
  end

  initial begin
    resetN = 1'b0;                          // Held from time zero
    repeat (resetCycles) @(posedge clock);
    #2 resetN = 1'b1;                       // Clear of the clock edge
  end

endmodule

// ==== tb/arrayHeapTb.sv ====
// Directed tests for arrayHeap: 4 blocks of 4 twelve-bit elements
// Inputs change 2 ns after a rising edge, results are read 2 ns after the next one
// The write test runs first while block 3 is still unallocated
`timescale 1ns/1ps

module arrayHeapTb import heapPkg::*; ();
  localparam int addressBits   = 2;
  localparam int indexBits     = 2;
  localparam int dataBits      = 12;
  localparam int arrayLength   = 2 ** indexBits;
  localparam int clockPeriod   = 20;
  localparam int timeoutCycles = 200;        // Roughly three times the test length

  logic                   clock;
  logic                   resetN;
  heapAction_t            action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    in;
  logic [dataBits-1:0]    out;
  heapError_t             error;

  int                  errorCount;
  logic [31:0]         lcgState;
  heapAction_t         lastAction;            // For error line labels
  logic [dataBits-1:0] modelElem [4][arrayLength];
  int                  modelSize [4];

  clockGen #(.period(clockPeriod), .resetCycles(3)) u_clockGen (.clock, .resetN);

  arrayHeap #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    u_arrayHeap (
    .clock, .resetN, .action, .array, .index, .in, .out, .error
  );

  //--------------------------------------------------
  // Helpers
  //--------------------------------------------------
  function automatic logic [dataBits-1:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[27:16];                   // Upper bits mix best
  endfunction

  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h",
               $time, signalName, actual, expected);
    end
  endtask

  task automatic issueAction(input heapAction_t act, input int blockNo, input int idx,
                             input logic [dataBits-1:0] data);
    lastAction = act;
    action     = act;
    array      = blockNo[addressBits-1:0];
    index      = idx[indexBits-1:0];
    in         = data;
    @(posedge clock);                         // DUT samples here
    #2;
    action = actIdle;                         // Outputs now settled
  endtask

  task automatic expectError(input heapError_t expError);
    checkValue($sformatf("error after %s", lastAction.name()), 32'(error), 32'(expError));
  endtask

  task automatic checkResult(input heapError_t expError, input logic [dataBits-1:0] expOut);
    expectError(expError);
    checkValue($sformatf("out after %s", lastAction.name()), 32'(out), 32'(expOut));
  endtask

  task automatic modelInsert(input int blockNo, input int idx,
                             input logic [dataBits-1:0] value);
    for (int k = arrayLength - 1; k > idx; k--) begin
      modelElem[blockNo][k] = modelElem[blockNo][k-1]; // Last one lost when full
    end
    modelElem[blockNo][idx] = value;
    if (modelSize[blockNo] < arrayLength) modelSize[blockNo]++;
  endtask

  task automatic modelRemove(input int blockNo, input int idx);
    for (int k = idx; k < arrayLength - 1; k++) begin
      modelElem[blockNo][k] = modelElem[blockNo][k+1];
    end
    modelSize[blockNo]--;
  endtask

  task automatic readBackBlock(input int blockNo);
    issueAction(actSize, blockNo, 0, '0);
    checkResult(errNone, modelSize[blockNo]);
    for (int k = 0; k < modelSize[blockNo]; k++) begin
      issueAction(actRead, blockNo, k, '0);
      checkResult(errNone, modelElem[blockNo][k]);
    end
  endtask

  //--------------------------------------------------
  // Directed tests
  //--------------------------------------------------
  task automatic writeAndReadBack();
    issueAction(actAlloc, 0, 0, '0);
    checkResult(errNone, 0);                  // First fresh block
    modelSize[0] = 0;
    for (int k = 0; k < 3; k++) begin
      modelElem[0][k] = nextRandom();
      issueAction(actWrite, 0, k, modelElem[0][k]);
      checkResult(errNone, modelElem[0][k]);  // Write echoes in
      modelSize[0] = k + 1;                   // Grows past the end
    end
    readBackBlock(0);
    issueAction(actRead, 0, 3, '0);
    expectError(errOutOfBounds);
    issueAction(actRead, 3, 0, '0);
    expectError(errNotAllocated);             // Above high-water count
  endtask

  task automatic allocateAndFree();
    for (int k = 1; k < 4; k++) begin
      issueAction(actAlloc, 0, 0, '0);
      checkResult(errNone, k);                // Fresh blocks in order
      modelSize[k] = 0;
    end
    issueAction(actAlloc, 0, 0, '0);
    expectError(errOutOfMemory);
    issueAction(actWrite, 1, 2, 12'h5a5);
    checkResult(errNone, 12'h5a5);            // Block 1 now holds three
    issueAction(actFree, 1, 0, '0);
    expectError(errNone);
    issueAction(actAlloc, 0, 0, '0);
    checkResult(errNone, 1);                  // Freed block reused first
    issueAction(actSize, 1, 0, '0);
    checkResult(errNone, 0);                  // Reused block starts empty
    issueAction(actFree, 1, 0, '0);
    expectError(errNone);
    issueAction(actFree, 1, 0, '0);
    expectError(errFreed);                    // Double free refused
    issueAction(actFree, 2, 0, '0);
    expectError(errNone);
    issueAction(actAlloc, 0, 0, '0);
    checkResult(errNone, 2);                  // Last freed comes back first
    issueAction(actAlloc, 0, 0, '0);
    checkResult(errNone, 1);
  endtask

  task automatic insertAndRemove();
    for (int k = 0; k < 3; k++) begin
      issueAction(actWrite, 2, k, k);
      checkResult(errNone, k);
      modelElem[2][k] = k;
    end
    issueAction(actResize, 2, 0, 3);
    expectError(errNone);
    modelSize[2] = 3;
    issueAction(actUp, 2, 2, 99);
    expectError(errNone);
    modelInsert(2, 2, 99);
    readBackBlock(2);                         // Size 4 holding 0 1 99 2
    issueAction(actDown, 2, 1, '0);
    checkResult(errNone, modelElem[2][1]);    // Removed element
    modelRemove(2, 1);
    readBackBlock(2);                         // Size 3 holding 0 99 2
  endtask

  task automatic pushAndPop();
    logic [dataBits-1:0] value;
    for (int k = 0; k < arrayLength; k++) begin
      value = nextRandom();
      issueAction(actPush, 3, 0, value);
      expectError(errNone);
      modelElem[3][modelSize[3]] = value;
      modelSize[3]++;
    end
    issueAction(actPush, 3, 0, nextRandom());
    expectError(errFull);
    for (int k = 0; k < arrayLength; k++) begin
      modelSize[3]--;
      issueAction(actPop, 3, 0, '0);
      checkResult(errNone, modelElem[3][modelSize[3]]); // Last in, first out
    end
    issueAction(actPop, 3, 0, '0);
    expectError(errEmpty);
  endtask

  task automatic applyUpdate(input heapAction_t op, input int blockNo, input int idx);
    logic [dataBits-1:0] operand;
    logic [dataBits-1:0] previous;
    logic [dataBits-1:0] updated;
    operand  = nextRandom();
    previous = modelElem[blockNo][idx];
    case (op)
      actSubtract: updated = previous - operand;  // Wraps at 12 bits
      actAnd:      updated = previous & operand;
      actOr:       updated = previous | operand;
      actXor:      updated = previous ^ operand;
      default:     updated = previous + operand;
    endcase
    modelElem[blockNo][idx] = updated;
    issueAction(op, blockNo, idx, operand);
    checkResult(errNone, (op == actAddAfter) ? previous : updated);
  endtask

  task automatic updateElements();
    applyUpdate(actAdd, 0, 0);
    applyUpdate(actAddAfter, 0, 1);           // Returns the old value
    applyUpdate(actSubtract, 0, 2);
    applyUpdate(actAnd, 0, 0);
    applyUpdate(actOr, 0, 1);
    applyUpdate(actXor, 0, 2);
    readBackBlock(0);                         // Stored values match
    issueAction(actResize, 0, 0, 5);
    expectError(errTooLarge);
    issueAction(actResize, 0, 0, 1);
    expectError(errNone);
    modelSize[0] = 1;
    readBackBlock(0);                         // Shrunk to one element
  endtask

  //--------------------------------------------------
  // Main sequence and watchdog
  //--------------------------------------------------
  initial begin
    errorCount = 0;
    lcgState   = 32'd27;                      // Fixed seed
    lastAction = actIdle;
    action     = actIdle;
    array      = '0;
    index      = '0;
    in         = '0;
    for (int k = 0; k < 4; k++) begin
      modelSize[k] = 0;
    end
    wait (resetN === 1'b1);
    @(posedge clock);
    #2;
    checkValue("out after reset", 32'(out), 32'd0);
    checkValue("error after reset", 32'(error), 32'(errNone));
    writeAndReadBack();
    allocateAndFree();
    insertAndRemove();
    pushAndPop();
    updateElements();
    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(timeoutCycles * clockPeriod);
    $display("Timeout: the tests did not finish within %0d clock periods", timeoutCycles);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/heapPkg.sv
rtl/heapIfs.sv
rtl/elementAlu.sv
rtl/elementStore.sv
rtl/sizeTable.sv
rtl/blockAllocator.sv
rtl/heapControl.sv
rtl/arrayHeap.sv
tb/clockGen.sv
tb/arrayHeapTb.sv
